// File: Bender.yml
package:
  name: ecc_store

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - ecc_store_pkg.sv
      - ecc_write_encoder.sv
      - ecc_word_array.sv
      - ecc_read_checker.sv
      - ecc_store_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - ecc_store_tb.sv

// File: ecc_read_checker.sv
// read side of the ECC store: syndrome, single error correction or double error flag, registered
`timescale 1ns/1ns
`include "ecc_store_settings.svh"

module ecc_read_checker (
   input  logic                           clk,
   input  logic                           rst_l,
   input  logic                           word_valid,
   input  ecc_store_pkg::ecc_word_t       word,
   input  logic                           sed_ded,
   output logic                           rd_valid,
   output ecc_store_pkg::ecc_rd_result_t  rd_result
);

   localparam int ham_w = `ECC_CHECK_W - 1;
   localparam int pos_w = `ECC_DATA_W + `ECC_CHECK_W;

   localparam logic [ham_w-1:0][`ECC_DATA_W-1:0] ham_mask = {
      `ECC_HAM_MASK5,
      `ECC_HAM_MASK4,
      `ECC_HAM_MASK3,
      `ECC_HAM_MASK2,
      `ECC_HAM_MASK1,
      `ECC_HAM_MASK0
   };

   logic [ham_w-1:0]            ham_syn;
   logic                        overall;
   logic [`ECC_CHECK_W-1:0]     syndrome;
   logic                        single_err;
   logic                        double_err;
   logic [pos_w-1:0]            pos_word;
   logic [pos_w-1:0]            flip_mask;
   logic [pos_w-1:0]            pos_fixed;
   ecc_store_pkg::ecc_data_t    fixed_data;
   ecc_store_pkg::ecc_check_t   fixed_check;

   // recompute each Hamming bit and compare with the stored one
   always_comb begin
      for (int i = 0; i < ham_w; i++) begin
         ham_syn[i] = word.check[i] ^ (^(word.data & ham_mask[i]));
      end
   end

   // parity of the whole stored word, odd means an odd number of flipped bits
   assign overall = (^word.data) ^ (^word.check);

   // detect-only mode drops the overall parity, so every error looks double
   assign syndrome = {overall & ~sed_ded, ham_syn};

   assign single_err = (syndrome != '0) && syndrome[ham_w];
   assign double_err = (syndrome != '0) && !syndrome[ham_w];

   // code word in Hamming position order, position 1 at bit 0
   // check bits sit at the powers of two, overall parity on top
   assign pos_word = {
      word.check[6],
      word.data[31:26],
      word.check[5],
      word.data[25:11],
      word.check[4],
      word.data[10:4],
      word.check[3],
      word.data[3:1],
      word.check[2],
      word.data[0],
      word.check[1:0]
   };

   // syndrome bits 5:0 name the failing position
   // zero with parity set means the overall parity bit itself flipped
   always_comb begin
      for (int i = 1; i < pos_w; i++) begin
         flip_mask[i-1] = single_err && (syndrome[ham_w-1:0] == ham_w'(i));
      end
      flip_mask[pos_w-1] = single_err && (syndrome[ham_w-1:0] == '0);
   end

   // on a double error the mask is empty and the word passes unchanged
   assign pos_fixed = pos_word ^ flip_mask;

   // back to data and check order
   assign fixed_data = {
      pos_fixed[37:32],
      pos_fixed[30:16],
      pos_fixed[14:8],
      pos_fixed[6:4],
      pos_fixed[2]
   };

   assign fixed_check = {
      pos_fixed[38],
      pos_fixed[31],
      pos_fixed[15],
      pos_fixed[7],
      pos_fixed[3],
      pos_fixed[1:0]
   };

   // result valid, two cycles after the read strobe
   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         rd_valid <= 1'b0;
      end else begin
         rd_valid <= word_valid;
      end
   end

   // result payload
   always_ff @(posedge clk) begin
      if (word_valid) begin
         rd_result.data       <= fixed_data;
         rd_result.check      <= fixed_check;
         rd_result.single_err <= single_err;
         rd_result.double_err <= double_err;
      end
   end

endmodule

// File: ecc_store_pkg.sv
// shared data, code word and request types of the ECC scratch store, used by scoped name
`include "ecc_store_settings.svh"

package ecc_store_pkg;

   // one payload word as seen by the user
   typedef logic [`ECC_DATA_W-1:0] ecc_data_t;

   // check bits, [5:0] Hamming and [6] overall parity
   typedef logic [`ECC_CHECK_W-1:0] ecc_check_t;

   // index of a stored word
   typedef logic [`ECC_ADDR_W-1:0] ecc_addr_t;

   // stored code word, 39 bits
   typedef struct packed {
      ecc_check_t check;
      ecc_data_t  data;
   } ecc_word_t;

   // registered write towards the array
   // word is already encoded and has any injected errors applied
   typedef struct packed {
      ecc_addr_t addr;
      ecc_word_t word;
   } ecc_wr_req_t;

   // checked read data
   // single_err means data and check were corrected
   // double_err means data and check are the raw stored bits
   typedef struct packed {
      ecc_data_t  data;
      ecc_check_t check;
      logic       single_err;
      logic       double_err;
   } ecc_rd_result_t;

endpackage

// File: ecc_store_settings.svh
// sizes and Hamming masks for the ECC scratch store, included by the package, RTL and testbench
`ifndef ECC_STORE_SETTINGS_SVH
`define ECC_STORE_SETTINGS_SVH

// number of stored code words and the address that selects one
`define ECC_DEPTH   16
`define ECC_ADDR_W  4

// payload and check bit widths, 6 Hamming bits plus one overall parity
`define ECC_DATA_W  32
`define ECC_CHECK_W 7

// data bits covered by Hamming check bits 0 to 5
`define ECC_HAM_MASK0 32'h56AA_AD5B
`define ECC_HAM_MASK1 32'h9B33_366D
`define ECC_HAM_MASK2 32'hE3C3_C78E
`define ECC_HAM_MASK3 32'h03FC_07F0
`define ECC_HAM_MASK4 32'h03FF_F800
`define ECC_HAM_MASK5 32'hFC00_0000

// check bit 6 is the parity of all data bits and check bits 5:0
`endif

// File: ecc_store_tb.sv
// directed testbench for the ECC scratch store, compiled from list.f with ecc_store_tb as top
`timescale 1ns/1ns
`include "ecc_store_settings.svh"

module ecc_store_tb;

   localparam int word_w    = `ECC_DATA_W + `ECC_CHECK_W;
   localparam int n_addr    = `ECC_DEPTH;
   localparam int n_clean   = 8;
   localparam int n_single  = word_w;
   localparam int n_double  = 8;
   localparam int n_sed     = 9;
   localparam int n_burst   = 4;
   localparam int wr_cycles = 3;
   localparam int rd_cycles = 2;

   // cycles the whole run needs, reset and idle checks included
   localparam int test_cycles = 10 + n_addr * rd_cycles
      + (n_clean + n_single + n_double + n_sed) * (wr_cycles + rd_cycles)
      + n_burst * wr_cycles + n_burst + 4;
   localparam int margin_ns = 500;

   logic                           clk;
   logic                           rst_l;
   logic                           wr_en;
   ecc_store_pkg::ecc_addr_t       wr_addr;
   ecc_store_pkg::ecc_data_t       wr_data;
   ecc_store_pkg::ecc_word_t       wr_inject;
   logic                           rd_en;
   ecc_store_pkg::ecc_addr_t       rd_addr;
   logic                           sed_ded;
   logic                           rd_valid;
   ecc_store_pkg::ecc_rd_result_t  rd_result;
   integer                         seed;

   tb_clock_gen u_clk_gen (
      .clk   (clk),
      .rst_l (rst_l)
   );

   ecc_store_top DUT (
      .clk       (clk),
      .rst_l     (rst_l),
      .wr_en     (wr_en),
      .wr_addr   (wr_addr),
      .wr_data   (wr_data),
      .wr_inject (wr_inject),
      .rd_en     (rd_en),
      .rd_addr   (rd_addr),
      .sed_ded   (sed_ded),
      .rd_valid  (rd_valid),
      .rd_result (rd_result)
   );

   // data bits covered by Hamming check bit i
   function automatic logic [`ECC_DATA_W-1:0] ham_mask(input int i);
      case (i)
         0: return `ECC_HAM_MASK0;
         1: return `ECC_HAM_MASK1;
         2: return `ECC_HAM_MASK2;
         3: return `ECC_HAM_MASK3;
         4: return `ECC_HAM_MASK4;
         default: return `ECC_HAM_MASK5;
      endcase
   endfunction

   // reference encoder, walks the data bits one by one
   function automatic ecc_store_pkg::ecc_word_t encode_ref(input ecc_store_pkg::ecc_data_t d);
      ecc_store_pkg::ecc_word_t  w;
      logic [`ECC_DATA_W-1:0]    m;
      logic                      p;
      w.data  = d;
      w.check = '0;
      for (int i = 0; i < `ECC_CHECK_W - 1; i++) begin
         m = ham_mask(i);
         for (int b = 0; b < `ECC_DATA_W; b++) begin
            if (m[b]) w.check[i] = w.check[i] ^ d[b];
         end
      end
      // overall bit makes the whole word even
      p = 1'b0;
      for (int b = 0; b < `ECC_DATA_W; b++) p = p ^ d[b];
      for (int i = 0; i < `ECC_CHECK_W - 1; i++) p = p ^ w.check[i];
      w.check[`ECC_CHECK_W-1] = p;
      return w;
   endfunction

   function automatic ecc_store_pkg::ecc_rd_result_t make_result(
      input ecc_store_pkg::ecc_data_t  d,
      input ecc_store_pkg::ecc_check_t c,
      input logic                      s,
      input logic                      dbl
   );
      ecc_store_pkg::ecc_rd_result_t r;
      r.data       = d;
      r.check      = c;
      r.single_err = s;
      r.double_err = dbl;
      return r;
   endfunction

   task automatic report_failure(input string what);
      $display("%s", what);
      $display("Errors found");
      $fatal(1);
   endtask

   task automatic check_data_word(input string name, input ecc_store_pkg::ecc_data_t exp,
                                  input ecc_store_pkg::ecc_data_t act);
      if (act !== exp) report_failure($sformatf("Fail %s expected 0x%h got 0x%h", name, exp, act));
   endtask

   task automatic compare_check_bits(input string name, input ecc_store_pkg::ecc_check_t exp,
                                     input ecc_store_pkg::ecc_check_t act);
      if (act !== exp) report_failure($sformatf("Fail %s expected 0x%h got 0x%h", name, exp, act));
   endtask

   task automatic verify_flag(input string name, input logic exp, input logic act);
      if (act !== exp) report_failure($sformatf("Fail %s expected 0x%h got 0x%h", name, exp, act));
   endtask

   task automatic tick();
      @(posedge clk);
      #1;
   endtask

   task automatic expect_result(input ecc_store_pkg::ecc_rd_result_t exp);
      if (rd_valid !== 1'b1) report_failure("read result did not arrive two cycles after rd_en");
      check_data_word("rd_result.data", exp.data, rd_result.data);
      compare_check_bits("rd_result.check", exp.check, rd_result.check);
      verify_flag("rd_result.single_err", exp.single_err, rd_result.single_err);
      verify_flag("rd_result.double_err", exp.double_err, rd_result.double_err);
   endtask

   // a write lands two edges later, the extra ticks keep the next read clear of it
   task automatic write_word(input ecc_store_pkg::ecc_addr_t a, input ecc_store_pkg::ecc_data_t d,
                             input ecc_store_pkg::ecc_word_t inj);
      wr_en     = 1'b1;
      wr_addr   = a;
      wr_data   = d;
      wr_inject = inj;
      tick();
      wr_en     = 1'b0;
      wr_inject = '0;
      tick();
      tick();
   endtask

   task automatic read_expect(input ecc_store_pkg::ecc_addr_t a,
                              input ecc_store_pkg::ecc_rd_result_t exp);
      rd_en   = 1'b1;
      rd_addr = a;
      tick();
      rd_en = 1'b0;
      if (rd_valid !== 1'b0) report_failure("rd_valid came one cycle after rd_en, too early");
      tick();
      expect_result(exp);
   endtask

   task automatic test_reset_state();
      for (int i = 0; i < 4; i++) begin
         verify_flag("rd_valid", 1'b0, rd_valid);
         tick();
      end
      for (int a = 0; a < n_addr; a++) begin
         read_expect(ecc_store_pkg::ecc_addr_t'(a), make_result('0, '0, 1'b0, 1'b0));
      end
   endtask

   task automatic test_clean_write_read();
      ecc_store_pkg::ecc_data_t  vals [n_clean];
      ecc_store_pkg::ecc_word_t  enc;
      for (int i = 0; i < n_clean; i++) begin
         vals[i] = $random(seed);
         write_word(ecc_store_pkg::ecc_addr_t'(2 * i + 1), vals[i], '0);
      end
      for (int i = 0; i < n_clean; i++) begin
         enc = encode_ref(vals[i]);
         read_expect(ecc_store_pkg::ecc_addr_t'(2 * i + 1),
                     make_result(vals[i], enc.check, 1'b0, 1'b0));
      end
   endtask

   // every data and check bit in turn, all corrected
   task automatic test_single_error();
      ecc_store_pkg::ecc_data_t  d;
      ecc_store_pkg::ecc_word_t  enc;
      ecc_store_pkg::ecc_word_t  inj;
      for (int b = 0; b < n_single; b++) begin
         d   = $random(seed);
         enc = encode_ref(d);
         inj = ecc_store_pkg::ecc_word_t'({{(word_w-1){1'b0}}, 1'b1} << b);
         write_word(ecc_store_pkg::ecc_addr_t'(b % n_addr), d, inj);
         read_expect(ecc_store_pkg::ecc_addr_t'(b % n_addr),
                     make_result(d, enc.check, 1'b1, 1'b0));
      end
   endtask

   task automatic test_double_error();
      ecc_store_pkg::ecc_data_t  d;
      ecc_store_pkg::ecc_word_t  enc;
      ecc_store_pkg::ecc_word_t  inj;
      ecc_store_pkg::ecc_word_t  stored;
      int                        b1;
      int                        b2;
      for (int i = 0; i < n_double; i++) begin
         d  = $random(seed);
         b1 = {$random(seed)} % word_w;
         b2 = {$random(seed)} % word_w;
         while (b2 == b1) b2 = {$random(seed)} % word_w;
         enc    = encode_ref(d);
         inj    = '0;
         inj    = inj | (ecc_store_pkg::ecc_word_t'(1) << b1);
         inj    = inj | (ecc_store_pkg::ecc_word_t'(1) << b2);
         stored = enc ^ inj;
         write_word(ecc_store_pkg::ecc_addr_t'(i), d, inj);
         read_expect(ecc_store_pkg::ecc_addr_t'(i),
                     make_result(stored.data, stored.check, 1'b0, 1'b1));
      end
   endtask

   // detect-only, a single data flip is flagged double and left as stored
   task automatic test_detect_only();
      ecc_store_pkg::ecc_data_t  d;
      ecc_store_pkg::ecc_word_t  enc;
      ecc_store_pkg::ecc_word_t  inj;
      ecc_store_pkg::ecc_word_t  stored;
      int                        b;
      sed_ded = 1'b1;
      for (int i = 0; i < n_sed - 1; i++) begin
         d      = $random(seed);
         b      = {$random(seed)} % `ECC_DATA_W;
         enc    = encode_ref(d);
         inj    = ecc_store_pkg::ecc_word_t'(1) << b;
         stored = enc ^ inj;
         write_word(ecc_store_pkg::ecc_addr_t'(i + 4), d, inj);
         read_expect(ecc_store_pkg::ecc_addr_t'(i + 4),
                     make_result(stored.data, enc.check, 1'b0, 1'b1));
      end
      // overall parity is ignored here, so its flip alone goes unseen
      d   = $random(seed);
      enc = encode_ref(d);
      inj = '0;
      inj.check[`ECC_CHECK_W-1] = 1'b1;
      write_word(ecc_store_pkg::ecc_addr_t'(15), d, inj);
      read_expect(ecc_store_pkg::ecc_addr_t'(15),
                  make_result(d, enc.check ^ inj.check, 1'b0, 1'b0));
      sed_ded = 1'b0;
   endtask

   task automatic test_burst_read();
      ecc_store_pkg::ecc_rd_result_t  exp [n_burst];
      ecc_store_pkg::ecc_addr_t       addr [n_burst];
      ecc_store_pkg::ecc_data_t       d;
      ecc_store_pkg::ecc_word_t       enc;
      for (int i = 0; i < n_burst; i++) begin
         d       = $random(seed) ^ i;
         enc     = encode_ref(d);
         addr[i] = ecc_store_pkg::ecc_addr_t'(4 * i + 2);
         exp[i]  = make_result(d, enc.check, 1'b0, 1'b0);
         write_word(addr[i], d, '0);
      end
      // one read per cycle, each result two cycles behind its request
      for (int i = 0; i < n_burst + 2; i++) begin
         if (i < n_burst) begin
            rd_en   = 1'b1;
            rd_addr = addr[i];
         end else begin
            rd_en = 1'b0;
         end
         if (i >= 2) expect_result(exp[i-2]);
         else verify_flag("rd_valid", 1'b0, rd_valid);
         tick();
      end
      verify_flag("rd_valid", 1'b0, rd_valid);
   endtask

   initial begin
      #(test_cycles * 20 + margin_ns);
      report_failure("timeout, the tests did not finish in the expected time");
   end

   initial begin
      seed      = 32'h60e8_2342;
      wr_en     = 1'b0;
      wr_addr   = '0;
      wr_data   = '0;
      wr_inject = '0;
      rd_en     = 1'b0;
      rd_addr   = '0;
      sed_ded   = 1'b0;
      wait (rst_l === 1'b1);
      tick();
      test_reset_state();
      test_clean_write_read();
      test_single_error();
      test_double_error();
      test_detect_only();
      test_burst_read();
      $display("No errors");
      $finish;
   end

endmodule

// File: ecc_store_top.sv
// top of the 16-word ECC scratch store: write encoder, word array and read checker in a chain
`timescale 1ns/1ns

module ecc_store_top (
   input  logic                           clk,
   input  logic                           rst_l,

   // write port
   input  logic                           wr_en,
   input  ecc_store_pkg::ecc_addr_t       wr_addr,
   input  ecc_store_pkg::ecc_data_t       wr_data,
   input  ecc_store_pkg::ecc_word_t       wr_inject,

   // read port
   input  logic                           rd_en,
   input  ecc_store_pkg::ecc_addr_t       rd_addr,
   input  logic                           sed_ded,
   output logic                           rd_valid,
   output ecc_store_pkg::ecc_rd_result_t  rd_result
);

   logic                        req_valid;
   ecc_store_pkg::ecc_wr_req_t  req;
   logic                        word_valid;
   ecc_store_pkg::ecc_word_t    word;

   ecc_write_encoder u_encoder (
      .clk       (clk),
      .rst_l     (rst_l),
      .wr_en     (wr_en),
      .wr_addr   (wr_addr),
      .wr_data   (wr_data),
      .wr_inject (wr_inject),
      .req_valid (req_valid),
      .req       (req)
   );

   ecc_word_array u_array (
      .clk        (clk),
      .rst_l      (rst_l),
      .req_valid  (req_valid),
      .req        (req),
      .rd_en      (rd_en),
      .rd_addr    (rd_addr),
      .word_valid (word_valid),
      .word       (word)
   );

   // checker sees the stored word one cycle after rd_en
   ecc_read_checker u_checker (
      .clk        (clk),
      .rst_l      (rst_l),
      .word_valid (word_valid),
      .word       (word),
      .sed_ded    (sed_ded),
      .rd_valid   (rd_valid),
      .rd_result  (rd_result)
   );

endmodule

// File: ecc_word_array.sv
// code word storage of the ECC store with per-word write enables and one registered read port
`timescale 1ns/1ns
`include "ecc_store_settings.svh"

module ecc_word_array (
   input  logic                        clk,
   input  logic                        rst_l,
   input  logic                        req_valid,
   input  ecc_store_pkg::ecc_wr_req_t  req,
   input  logic                        rd_en,
   input  ecc_store_pkg::ecc_addr_t    rd_addr,
   output logic                        word_valid,
   output ecc_store_pkg::ecc_word_t    word
);

   ecc_store_pkg::ecc_word_t  mem [`ECC_DEPTH];
   logic [`ECC_DEPTH-1:0]     word_en;

   // one-hot decode of the write address
   always_comb begin
      for (int i = 0; i < `ECC_DEPTH; i++) begin
         word_en[i] = req_valid && (req.addr == ecc_store_pkg::ecc_addr_t'(i));
      end
   end

   // each word is its own enabled flop, idle words hold
   // all-zero after reset is a valid code word
   for (genvar g = 0; g < `ECC_DEPTH; g++) begin : g_word
      always_ff @(posedge clk or negedge rst_l) begin
         if (!rst_l) begin
            mem[g] <= '0;
         end else if (word_en[g]) begin
            mem[g] <= req.word;
         end
      end
   end

   // read valid, one cycle after rd_en
   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         word_valid <= 1'b0;
      end else begin
         word_valid <= rd_en;
      end
   end

   // read data register
   // a write landing on the same edge is not forwarded
   always_ff @(posedge clk) begin
      if (rd_en) begin
         word <= mem[rd_addr];
      end
   end

endmodule

// File: ecc_write_encoder.sv
// write side of the ECC store: encodes data into a code word, applies injection, registers it
`timescale 1ns/1ns
`include "ecc_store_settings.svh"

module ecc_write_encoder (
   input  logic                        clk,
   input  logic                        rst_l,
   input  logic                        wr_en,
   input  ecc_store_pkg::ecc_addr_t    wr_addr,
   input  ecc_store_pkg::ecc_data_t    wr_data,
   input  ecc_store_pkg::ecc_word_t    wr_inject,
   output logic                        req_valid,
   output ecc_store_pkg::ecc_wr_req_t  req
);

   localparam int ham_w = `ECC_CHECK_W - 1;

   // entry i holds the data bits covered by Hamming bit i
   localparam logic [ham_w-1:0][`ECC_DATA_W-1:0] ham_mask = {
      `ECC_HAM_MASK5,
      `ECC_HAM_MASK4,
      `ECC_HAM_MASK3,
      `ECC_HAM_MASK2,
      `ECC_HAM_MASK1,
      `ECC_HAM_MASK0
   };

   logic [ham_w-1:0]          ham_bits;
   logic                      par_bit;
   ecc_store_pkg::ecc_word_t  code;
   ecc_store_pkg::ecc_word_t  coded;

   // Hamming bits, one parity tree per mask
   always_comb begin
      for (int i = 0; i < ham_w; i++) begin
         ham_bits[i] = ^(wr_data & ham_mask[i]);
      end
   end

   // overall parity over data and the six Hamming bits
   // makes the full 39-bit word even, so single and double errors can be told apart
   assign par_bit = (^wr_data) ^ (^ham_bits);

   always_comb begin
      code.data  = wr_data;
      code.check = {par_bit, ham_bits};
   end

   // error injection for test, zero in normal use
   assign coded = code ^ wr_inject;

   // valid bit
   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         req_valid <= 1'b0;
      end else begin
         req_valid <= wr_en;
      end
   end

   // request payload, only loaded on a write
   always_ff @(posedge clk) begin
      if (wr_en) begin
         req.addr <= wr_addr;
         req.word <= coded;
      end
   end

endmodule

// File: list.f
+incdir+.
ecc_store_pkg.sv
ecc_write_encoder.sv
ecc_word_array.sv
ecc_read_checker.sv
ecc_store_top.sv
tb_clock_gen.sv
ecc_store_tb.sv

// File: tb_clock_gen.sv
// clock and reset source for the ECC store testbench, 10 ns period, reset held for 5 cycles
`timescale 1ns/1ns

module tb_clock_gen (
   output logic clk,
   output logic rst_l
);

   localparam int half_period  = 5;
   localparam int reset_cycles = 5;

   initial begin
      clk = 1'b0;
      forever #half_period clk = ~clk;
   end

   // release just after an edge, away from the sampling point
   initial begin
      rst_l = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      #1;
      rst_l = 1'b1;
   end

endmodule
